//--- mem_wb.f
+incdir+verilog
verilog/datapath_pkg.sv
verilog/pipe_ctrl_pkg.sv
verilog/stage_if.sv
verilog/memory_stage.sv
verilog/data_ram.sv
verilog/writeback_stage.sv
verilog/mem_wb_top.sv
tb/mem_wb_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the mem_wb testbench with Verilator, run it and look for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --top-module mem_wb_tb -f mem_wb.f -o mem_wb_sim > build.log 2>&1 \
    && ./obj_dir/mem_wb_sim > sim.log 2>&1 \
    || { echo "Build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^=== PASS ===$" sim.log && exit 0 || exit 1

//--- tb/mem_wb_tb.sv
`timescale 1ns/1ps
`include "mem_wb_settings.svh"

module mem_wb_tb
    import datapath_pkg::*, pipe_ctrl_pkg::*;
();

    localparam int SEED         = 81971;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;
    localparam int PIPE_DEPTH   = 3;                  // Edges from input to output
    localparam int NUM_PAIRS    = 16;                 // Back-to-back store and load pairs
    localparam int NUM_RANDOM   = 400;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 2 * NUM_PAIRS + NUM_RANDOM + PIPE_DEPTH;
    localparam int TIMEOUT_NS   = (TOTAL_CYCLES + 20) * CLK_PERIOD;

    typedef struct packed {
        logic     valid;
        logic     we;
        logic     redirect;
        reg_idx_t waddr;
        word_t    wdata;
    } expect_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     in_valid;
    addr_t    alu_result;
    word_t    store_data;
    addr_t    link_addr;
    logic     mem_read;
    logic     mem_write;
    logic     reg_write;
    reg_idx_t reg_dest;
    wb_sel_t  wb_sel;
    logic     pc_src;
    logic     wb_valid;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;
    logic     pc_redirect;

    word_t       model_mem [`MEM_WORDS];             // Reference copy of the data RAM
    expect_t     expect_q [$];                       // Delay line of expected outputs
    expect_t     idle_entry;
    logic [31:0] pair_rnd;
    addr_t       pair_addr;

    mem_wb_top DUT (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .alu_result  (alu_result),
        .store_data  (store_data),
        .link_addr   (link_addr),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .reg_write   (reg_write),
        .reg_dest    (reg_dest),
        .wb_sel      (wb_sel),
        .pc_src      (pc_src),
        .wb_valid    (wb_valid),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .pc_redirect (pc_redirect)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("Error: %s got 0x%08h expected 0x%08h at %0t", name, got, expected, $time);
            $display("=== FAIL ===");
            $fatal(1, "output mismatch on %s", name);
        end
    endtask

    task automatic compare_outputs(input expect_t e);
        check_value("wb_valid", 32'(wb_valid), 32'(e.valid));
        check_value("rf_we", 32'(rf_we), 32'(e.we));
        check_value("pc_redirect", 32'(pc_redirect), 32'(e.redirect));
        if (e.valid)                                  // Data fields only count for a retired bundle
        begin
            check_value("rf_waddr", 32'(rf_waddr), 32'(e.waddr));
            check_value("rf_wdata", rf_wdata, e.wdata);
        end
    endtask

    // One falling edge: check the oldest bundle, drive a new one and predict its result
    task automatic apply_bundle(input logic v, input addr_t alu, input word_t sdata,
                                input addr_t link, input logic rd, input logic wr,
                                input logic rw, input reg_idx_t dest, input wb_sel_t sel,
                                input logic br);
        expect_t    e;
        mem_index_t idx;
        @(negedge clk);
        if (expect_q.size() == PIPE_DEPTH)
            compare_outputs(expect_q.pop_front());
        in_valid   = v;
        alu_result = alu;
        store_data = sdata;
        link_addr  = link;
        mem_read   = rd;
        mem_write  = wr;
        reg_write  = rw;
        reg_dest   = dest;
        wb_sel     = sel;
        pc_src     = br;
        idx        = alu[2 +: `MEM_INDEX_W];          // Word index, byte offset ignored
        e.valid    = v;
        e.we       = v & rw & (dest != 5'd0);
        e.redirect = v & br;
        e.waddr    = dest;
        case (sel)
            2'd1:    e.wdata = rd ? model_mem[idx] : '0;
            2'd2:    e.wdata = link;
            default: e.wdata = alu;
        endcase
        if (v && wr)
            model_mem[idx] = sdata;                   // Read sees the old word first
        expect_q.push_back(e);
    endtask

    function automatic addr_t random_mem_addr();
        logic [31:0] rnd;
        logic [31:0] pick;
        addr_t       addr;
        rnd  = $urandom;
        pick = $urandom;
        addr = $urandom;
        if (rnd[0])
            addr[2 +: 3] = pick[2:0];                 // Small window so indices repeat
        else
            addr[2 +: `MEM_INDEX_W] = pick[`MEM_INDEX_W-1:0];
        return addr;
    endfunction

    task automatic random_bundle(input bit allow_gap);
        logic [31:0] rnd;
        int          kind;
        addr_t       alu;
        reg_idx_t    dest;
        rnd  = $urandom;
        kind = int'($urandom % 5);
        alu  = $urandom;
        dest = (rnd[7:5] == 3'd0) ? 5'd0 : rnd[4:0];
        if (allow_gap && rnd[18:16] == 3'd0)          // Bubble with junk fields, may carry a store
            apply_bundle(1'b0, random_mem_addr(), $urandom, $urandom, rnd[8], rnd[9],
                         rnd[10], dest, rnd[12:11], rnd[13]);
        else
            case (kind)
                0: apply_bundle(1'b1, random_mem_addr(), $urandom, $urandom, 1'b0, 1'b1,
                                1'b0, dest, rnd[12:11], 1'b0);
                1: apply_bundle(1'b1, random_mem_addr(), $urandom, $urandom, 1'b1, 1'b0,
                                1'b1, dest, 2'd1, 1'b0);
                2: apply_bundle(1'b1, alu, $urandom, $urandom, 1'b0, 1'b0, rnd[10], dest,
                                rnd[14] ? 2'd3 : 2'd0, rnd[15] & rnd[13]);
                3: apply_bundle(1'b1, alu, $urandom, $urandom, 1'b0, 1'b0, 1'b1, dest,
                                2'd2, 1'b1);
                default: apply_bundle(1'b1, alu, $urandom, $urandom, 1'b0, 1'b0, 1'b0,
                                      dest, 2'd0, 1'b1);
            endcase
    endtask

    initial
    begin
        void'($urandom(SEED));
        for (int k = 0; k < `MEM_WORDS; k++)
            model_mem[k] = '0;
        rst        = 1'b1;
        in_valid   = 1'b0;
        alu_result = '0;
        store_data = '0;
        link_addr  = '0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        reg_write  = 1'b0;
        reg_dest   = '0;
        wb_sel     = '0;
        pc_src     = 1'b0;
        idle_entry = '0;
        repeat (RESET_CYCLES)
        begin
            @(negedge clk);
            compare_outputs(idle_entry);
        end
        rst = 1'b0;
        repeat (PIPE_DEPTH)
            expect_q.push_back(idle_entry);            // Pipeline is empty after reset

        for (int i = 0; i < NUM_PAIRS; i++)
        begin
            pair_addr = random_mem_addr();
            pair_rnd  = $urandom;
            apply_bundle(1'b1, pair_addr, $urandom, $urandom, 1'b0, 1'b1, 1'b0, 5'd0,
                         2'd0, 1'b0);
            apply_bundle(1'b1, pair_addr, $urandom, $urandom, 1'b1, 1'b0, 1'b1,
                         pair_rnd[4:0] | 5'd1, 2'd1, 1'b0);
        end
        for (int i = 0; i < NUM_RANDOM; i++)
            random_bundle(1'b1);
        repeat (PIPE_DEPTH)                           // Drain the last bundles
            apply_bundle(1'b0, '0, '0, '0, 1'b0, 1'b0, 1'b0, 5'd0, 2'd0, 1'b0);

        $display("=== PASS ===");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: the test did not finish within %0d ns", TIMEOUT_NS);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- verilog/mem_wb_top.sv
`timescale 1ns/1ps

module mem_wb_top
    import datapath_pkg::*, pipe_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  addr_t    alu_result,
    input  word_t    store_data,
    input  addr_t    link_addr,
    input  logic     mem_read,
    input  logic     mem_write,
    input  logic     reg_write,
    input  reg_idx_t reg_dest,
    input  wb_sel_t  wb_sel,
    input  logic     pc_src,
    output logic     wb_valid,
    output logic     rf_we,
    output reg_idx_t rf_waddr,
    output word_t    rf_wdata,
    output logic     pc_redirect
);

    stage_if ex_mem_bus ();
    stage_if mem_wb_bus ();

    mem_index_t ram_index;
    word_t      ram_wdata;
    logic       ram_we;
    word_t      ram_rdata;

    // Execute side bundle
    assign ex_mem_bus.valid      = in_valid;
    assign ex_mem_bus.alu_result = alu_result;
    assign ex_mem_bus.store_data = store_data;
    assign ex_mem_bus.link_addr  = link_addr;
    assign ex_mem_bus.mem_read   = mem_read;
    assign ex_mem_bus.mem_write  = mem_write;
    assign ex_mem_bus.reg_write  = reg_write;
    assign ex_mem_bus.reg_dest   = reg_dest;
    assign ex_mem_bus.wb_sel     = wb_sel;
    assign ex_mem_bus.pc_src     = pc_src;

    memory_stage u_memory_stage (
        .clk       (clk),
        .rst       (rst),
        .ex        (ex_mem_bus.dst),
        .wb        (mem_wb_bus.src),
        .ram_index (ram_index),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we),
        .ram_rdata (ram_rdata)
    );

    data_ram u_data_ram (
        .clk       (clk),
        .ram_index (ram_index),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we),
        .ram_rdata (ram_rdata)
    );

    writeback_stage u_writeback_stage (
        .clk         (clk),
        .rst         (rst),
        .mem         (mem_wb_bus.dst),
        .wb_valid    (wb_valid),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .pc_redirect (pc_redirect)
    );

endmodule

//--- verilog/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage
    import datapath_pkg::*, pipe_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    stage_if.dst     mem,          // Bundle from the memory stage
    output logic     wb_valid,
    output logic     rf_we,
    output reg_idx_t rf_waddr,
    output word_t    rf_wdata,
    output logic     pc_redirect
);

    word_t result;
    logic  we_next;

    always_comb
    begin
        case (mem.wb_sel)
            WB_ALU:  result = mem.alu_result;
            WB_LOAD: result = mem.store_data;
            WB_LINK: result = mem.link_addr;
            default: result = mem.alu_result;  // Unused code
        endcase
    end

    // Writes to the zero register are dropped here
    assign we_next = mem.valid & mem.reg_write & (mem.reg_dest != ZERO_REG);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wb_valid    <= 1'b0;
            rf_we       <= 1'b0;
            pc_redirect <= 1'b0;
        end
        else
        begin
            wb_valid    <= mem.valid;               // One pulse per retired bundle
            rf_we       <= we_next;
            pc_redirect <= mem.valid & mem.pc_src;
        end
    end

    always_ff @(posedge clk)
    begin
        rf_waddr <= mem.reg_dest;
        rf_wdata <= result;
    end

endmodule

//--- verilog/data_ram.sv
`timescale 1ns/1ps
`include "mem_wb_settings.svh"

module data_ram
    import datapath_pkg::*;
(
    input  logic       clk,
    input  mem_index_t ram_index,
    input  word_t      ram_wdata,
    input  logic       ram_we,
    output word_t      ram_rdata
);

    // Starts out all zero
    word_t mem_array [`MEM_WORDS] = '{default: '0};

    always_ff @(posedge clk)
    begin
        if (ram_we)
        begin
            mem_array[ram_index] <= ram_wdata;
        end
    end

    // Read-before-write on the same index
    always_ff @(posedge clk)
    begin
        ram_rdata <= mem_array[ram_index];
    end

endmodule

//--- verilog/memory_stage.sv
`timescale 1ns/1ps

module memory_stage
    import datapath_pkg::*, pipe_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    stage_if.dst       ex,           // Bundle from execute
    stage_if.src       wb,           // Bundle toward write-back
    output mem_index_t ram_index,
    output word_t      ram_wdata,
    output logic       ram_we,
    input  word_t      ram_rdata
);

    logic     req_valid;
    logic     req_mem_read;
    logic     req_mem_write;
    logic     req_reg_write;
    logic     req_pc_src;
    addr_t    req_alu;
    word_t    req_sdata;
    addr_t    req_link;
    reg_idx_t req_dest;
    wb_sel_t  req_wb_sel;

    logic     rsp_valid;
    logic     rsp_mem_read;
    logic     rsp_mem_write;
    logic     rsp_reg_write;
    logic     rsp_pc_src;
    addr_t    rsp_alu;
    addr_t    rsp_link;
    reg_idx_t rsp_dest;
    wb_sel_t  rsp_wb_sel;

    // EX/MEM register set that issues the RAM request
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            req_valid     <= 1'b0;
            req_mem_read  <= 1'b0;
            req_mem_write <= 1'b0;
            req_reg_write <= 1'b0;
            req_pc_src    <= 1'b0;
        end
        else
        begin
            req_valid     <= ex.valid;
            req_mem_read  <= ex.mem_read;
            req_mem_write <= ex.mem_write;
            req_reg_write <= ex.reg_write;
            req_pc_src    <= ex.pc_src;
        end
    end

    always_ff @(posedge clk)
    begin
        req_alu    <= ex.alu_result;
        req_sdata  <= ex.store_data;
        req_link   <= ex.link_addr;
        req_dest   <= ex.reg_dest;
        req_wb_sel <= ex.wb_sel;
    end

    assign ram_index = req_alu[BYTE_OFS_W +: $bits(mem_index_t)];  // Word aligned
    assign ram_wdata = req_sdata;
    assign ram_we    = req_valid & req_mem_write;                   // Only a valid store writes

    // Second set lines the bundle up with the registered RAM read
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rsp_valid     <= 1'b0;
            rsp_mem_read  <= 1'b0;
            rsp_mem_write <= 1'b0;
            rsp_reg_write <= 1'b0;
            rsp_pc_src    <= 1'b0;
        end
        else
        begin
            rsp_valid     <= req_valid;
            rsp_mem_read  <= req_mem_read;
            rsp_mem_write <= req_mem_write;
            rsp_reg_write <= req_reg_write;
            rsp_pc_src    <= req_pc_src;
        end
    end

    always_ff @(posedge clk)
    begin
        rsp_alu    <= req_alu;
        rsp_link   <= req_link;
        rsp_dest   <= req_dest;
        rsp_wb_sel <= req_wb_sel;
    end

    assign wb.valid      = rsp_valid;
    assign wb.alu_result = rsp_alu;
    assign wb.store_data = rsp_mem_read ? ram_rdata : '0;  // Load data rides here
    assign wb.link_addr  = rsp_link;
    assign wb.mem_read   = rsp_mem_read;
    assign wb.mem_write  = rsp_mem_write;
    assign wb.reg_write  = rsp_reg_write;
    assign wb.reg_dest   = rsp_dest;
    assign wb.wb_sel     = rsp_wb_sel;
    assign wb.pc_src     = rsp_pc_src;

endmodule

//--- verilog/stage_if.sv
`timescale 1ns/1ps

interface stage_if
    import datapath_pkg::*, pipe_ctrl_pkg::*;
();

    logic     valid;        // Fields below count only while this is high
    addr_t    alu_result;   // ALU value or memory byte address
    word_t    store_data;   // Store data toward MEM and load data toward WB
    addr_t    link_addr;    // Return address for jump-and-link
    logic     mem_read;
    logic     mem_write;
    logic     reg_write;
    reg_idx_t reg_dest;
    wb_sel_t  wb_sel;
    logic     pc_src;       // Branch or jump taken

    // Producing stage
    modport src (
        output valid, alu_result, store_data, link_addr,
        output mem_read, mem_write, reg_write, reg_dest,
        output wb_sel, pc_src
    );

    // Consuming stage
    modport dst (
        input valid, alu_result, store_data, link_addr,
        input mem_read, mem_write, reg_write, reg_dest,
        input wb_sel, pc_src
    );

endinterface

//--- verilog/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    typedef logic [4:0] reg_idx_t;               // Register file index
    typedef logic [1:0] wb_sel_t;                // Write-back result selector

    // Result sources for write-back
    localparam wb_sel_t WB_ALU  = 2'd0;
    localparam wb_sel_t WB_LOAD = 2'd1;
    localparam wb_sel_t WB_LINK = 2'd2;          // Code 3 falls back to the ALU value

    localparam reg_idx_t ZERO_REG = 5'd0;        // Hardwired zero register

endpackage

//--- verilog/datapath_pkg.sv
`include "mem_wb_settings.svh"

package datapath_pkg;

    typedef logic [31:0] word_t;                   // Data word for ALU, store and load values
    typedef logic [31:0] addr_t;                   // Byte address

    typedef logic [`MEM_INDEX_W-1:0] mem_index_t;  // Word index into the data RAM

    // Low address bits that select a byte inside a word
    localparam int BYTE_OFS_W = 2;

endpackage

//--- verilog/mem_wb_settings.svh
`ifndef MEM_WB_SETTINGS_SVH
`define MEM_WB_SETTINGS_SVH

// Depth of the data RAM in 32-bit words
`define MEM_WORDS   256

// Width of the word index, log2 of the depth
`define MEM_INDEX_W 8

`endif
